// File: verilog/issue_pkg.sv
package issue_pkg;

    localparam int op_w    = 6;
    localparam int funct_w = 6;
    localparam int sub_w   = 5;   // REGIMM rt and COP0 rs

    typedef enum logic [op_w-1:0] {
        OP_SPECIAL = 6'b000000,
        OP_REGIMM  = 6'b000001,
        OP_J       = 6'b000010,
        OP_JAL     = 6'b000011,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_BLEZ    = 6'b000110,
        OP_BGTZ    = 6'b000111,
        OP_ADDI    = 6'b001000,
        OP_ADDIU   = 6'b001001,
        OP_SLTI    = 6'b001010,
        OP_SLTIU   = 6'b001011,
        OP_ANDI    = 6'b001100,
        OP_ORI     = 6'b001101,
        OP_XORI    = 6'b001110,
        OP_LUI     = 6'b001111,
        OP_COP0    = 6'b010000,
        OP_LB      = 6'b100000,
        OP_LH      = 6'b100001,
        OP_LW      = 6'b100011,
        OP_LBU     = 6'b100100,
        OP_LHU     = 6'b100101,
        OP_SB      = 6'b101000,
        OP_SH      = 6'b101001,
        OP_SW      = 6'b101011
    } op_e;

    typedef enum logic [funct_w-1:0] {
        FN_SLL     = 6'b000000, FN_SRL     = 6'b000010,
        FN_SRA     = 6'b000011, FN_SLLV    = 6'b000100,
        FN_SRLV    = 6'b000110, FN_SRAV    = 6'b000111,
        FN_JR      = 6'b001000, FN_JALR    = 6'b001001,
        FN_SYSCALL = 6'b001100, FN_BREAK   = 6'b001101,
        FN_MFHI    = 6'b010000, FN_MTHI    = 6'b010001,
        FN_MFLO    = 6'b010010, FN_MTLO    = 6'b010011,
        FN_MULT    = 6'b011000, FN_MULTU   = 6'b011001,
        FN_DIV     = 6'b011010, FN_DIVU    = 6'b011011,
        FN_ADD     = 6'b100000, FN_ADDU    = 6'b100001,
        FN_SUB     = 6'b100010, FN_SUBU    = 6'b100011,
        FN_AND     = 6'b100100, FN_OR      = 6'b100101,
        FN_XOR     = 6'b100110, FN_NOR     = 6'b100111,
        FN_SLT     = 6'b101010, FN_SLTU    = 6'b101011
    } funct_e;

    // ERET under COP0 reuses the MULT funct code
    localparam funct_e FN_ERET = FN_MULT;

    typedef enum logic [sub_w-1:0] {
        RI_BLTZ    = 5'b00000,
        RI_BGEZ    = 5'b00001,
        RI_BLTZAL  = 5'b10000,
        RI_BGEZAL  = 5'b10001
    } regimm_e;

    typedef enum logic [sub_w-1:0] {
        C0_MF      = 5'b00000,
        C0_MT      = 5'b00100
    } c0_e;

    typedef enum logic [6:0] {
        INSTR_INVALID,
        ADD, ADDU, SUB, SUBU, SLT, SLTU,
        AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        MULT, MULTU, DIV, DIVU,
        JR, JALR, MFHI, MFLO, MTHI, MTLO,
        SYSCALL, BREAK,
        ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
        BEQ, BNE, BLEZ, BGTZ,
        BLTZ, BGEZ, BLTZAL, BGEZAL, REGIMM_OTHER,
        J, JAL,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        ERET, MFC0, MTC0
    } instr_e;

    typedef enum logic [1:0] {
        REGDST_RT  = 2'b00,
        REGDST_RD  = 2'b01,
        REGDST_R31 = 2'b10
    } regdst_e;

endpackage

// File: verilog/inst_identify.sv
`timescale 1ns/100ps

module inst_identify
    import issue_pkg::*;
(
    input  logic [op_w-1:0]    d_op,
    input  logic [funct_w-1:0] d_funct,
    input  logic [sub_w-1:0]   d_branchfunct,
    input  logic [sub_w-1:0]   d_c0funct,
    output instr_e             instr
);

    always_comb
    begin
        instr = INSTR_INVALID;
        case (d_op)
            OP_SPECIAL:
            begin
                case (d_funct)
                    FN_ADD:     instr = ADD;
                    FN_ADDU:    instr = ADDU;
                    FN_SUB:     instr = SUB;
                    FN_SUBU:    instr = SUBU;
                    FN_SLT:     instr = SLT;
                    FN_SLTU:    instr = SLTU;
                    FN_AND:     instr = AND;
                    FN_OR:      instr = OR;
                    FN_XOR:     instr = XOR;
                    FN_NOR:     instr = NOR;
                    FN_SLL:     instr = SLL;
                    FN_SRL:     instr = SRL;
                    FN_SRA:     instr = SRA;
                    FN_SLLV:    instr = SLLV;
                    FN_SRLV:    instr = SRLV;
                    FN_SRAV:    instr = SRAV;
                    FN_MULT:    instr = MULT;
                    FN_MULTU:   instr = MULTU;
                    FN_DIV:     instr = DIV;
                    FN_DIVU:    instr = DIVU;
                    FN_JR:      instr = JR;
                    FN_JALR:    instr = JALR;
                    FN_MFHI:    instr = MFHI;
                    FN_MFLO:    instr = MFLO;
                    FN_MTHI:    instr = MTHI;
                    FN_MTLO:    instr = MTLO;
                    FN_SYSCALL: instr = SYSCALL;
                    FN_BREAK:   instr = BREAK;
                    default:    instr = INSTR_INVALID;
                endcase
            end
            OP_REGIMM:
            begin
                case (d_branchfunct)
                    RI_BLTZ:   instr = BLTZ;
                    RI_BGEZ:   instr = BGEZ;
                    RI_BLTZAL: instr = BLTZAL;
                    RI_BGEZAL: instr = BGEZAL;
                    default:   instr = REGIMM_OTHER;   // Treated as a linking branch
                endcase
            end
            OP_COP0:
            begin
                if (d_funct == FN_ERET)                // ERET wins over rs
                    instr = ERET;
                else if (d_c0funct == C0_MF)
                    instr = MFC0;
                else if (d_c0funct == C0_MT)
                    instr = MTC0;
                else
                    instr = INSTR_INVALID;
            end
            OP_ADDI:  instr = ADDI;
            OP_ADDIU: instr = ADDIU;
            OP_SLTI:  instr = SLTI;
            OP_SLTIU: instr = SLTIU;
            OP_ANDI:  instr = ANDI;
            OP_ORI:   instr = ORI;
            OP_XORI:  instr = XORI;
            OP_LUI:   instr = LUI;
            OP_BEQ:   instr = BEQ;
            OP_BNE:   instr = BNE;
            OP_BLEZ:  instr = BLEZ;
            OP_BGTZ:  instr = BGTZ;
            OP_J:     instr = J;
            OP_JAL:   instr = JAL;
            OP_LB:    instr = LB;
            OP_LBU:   instr = LBU;
            OP_LH:    instr = LH;
            OP_LHU:   instr = LHU;
            OP_LW:    instr = LW;
            OP_SB:    instr = SB;
            OP_SH:    instr = SH;
            OP_SW:    instr = SW;
            default:  instr = INSTR_INVALID;
        endcase
    end

endmodule

// File: verilog/dest_decode.sv
`timescale 1ns/100ps

module dest_decode
    import issue_pkg::*;
(
    input  instr_e  instr,
    output logic    regwrite,
    output logic    hiwrite,
    output logic    lowrite,
    output logic    cp0write,
    output regdst_e regdst
);

    always_comb
    begin
        regwrite = 1'b0;
        regdst   = REGDST_RT;
        case (instr)
            ADD, ADDU, SUB, SUBU, SLT, SLTU,
            AND, OR, XOR, NOR,
            SLL, SRL, SRA, SLLV, SRLV, SRAV,
            JALR, MFHI, MFLO:
            begin
                regwrite = 1'b1;
                regdst   = REGDST_RD;
            end
            ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
            LB, LBU, LH, LHU, LW,
            MFC0:
            begin
                regwrite = 1'b1;                 // Result lands in rt
                regdst   = REGDST_RT;
            end
            BLTZAL, BGEZAL, REGIMM_OTHER, JAL:
            begin
                regwrite = 1'b1;
                regdst   = REGDST_R31;           // Link address
            end
            default:
            begin
                regwrite = 1'b0;
                regdst   = REGDST_RT;
            end
        endcase
    end

    // Multiply and divide fill both halves
    assign hiwrite  = instr inside {MTHI, MULT, MULTU, DIV, DIVU};
    assign lowrite  = instr inside {MTLO, MULT, MULTU, DIV, DIVU};
    assign cp0write = (instr == MTC0);

endmodule

// File: verilog/operand_decode.sv
`timescale 1ns/100ps

module operand_decode
    import issue_pkg::*;
(
    input  instr_e instr,
    output logic   needrs,
    output logic   needrt,
    output logic   needhi,
    output logic   needlo,
    output logic   needcp0
);

    // Shifts by shamt, MFHI/MFLO, BREAK, SYSCALL and LUI leave rs unread
    assign needrs = instr inside {
        ADD, ADDU, SUB, SUBU, SLT, SLTU,
        AND, OR, XOR, NOR,
        SLLV, SRLV, SRAV,
        MULT, MULTU, DIV, DIVU,
        JR, JALR, MTHI, MTLO,
        ADDI, ADDIU, SLTI, SLTIU, ANDI, ORI, XORI,
        BEQ, BNE, BLEZ, BGTZ,
        BLTZ, BGEZ, BLTZAL, BGEZAL, REGIMM_OTHER,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW
    };

    assign needrt = instr inside {
        ADD, ADDU, SUB, SUBU, SLT, SLTU,
        AND, OR, XOR, NOR,
        SLL, SRL, SRA, SLLV, SRLV, SRAV,
        MULT, MULTU, DIV, DIVU,
        BEQ, BNE,
        SB, SH, SW,                          // Store data
        MTC0
    };

    assign needhi  = (instr == MFHI);
    assign needlo  = (instr == MFLO);
    assign needcp0 = instr inside {ERET, MFC0};   // ERET reads EPC

endmodule

// File: verilog/pipe_class_decode.sv
`timescale 1ns/100ps

module pipe_class_decode
    import issue_pkg::*;
(
    input  instr_e instr,
    output logic   isbranch,
    output logic   isjump,
    output logic   memreq
);

    // Every REGIMM encoding counts as a branch
    assign isbranch = instr inside {
        BEQ, BNE, BLEZ, BGTZ,
        BLTZ, BGEZ, BLTZAL, BGEZAL, REGIMM_OTHER
    };

    assign isjump = instr inside {JR, JALR, J, JAL};

    assign memreq = instr inside {
        LB, LBU, LH, LHU, LW,
        SB, SH, SW
    };

endmodule

// File: verilog/issue_controller.sv
`timescale 1ns/100ps

module issue_controller
    import issue_pkg::*;
(
    input  logic [op_w-1:0]    d_op,
    input  logic [funct_w-1:0] d_funct,
    input  logic [sub_w-1:0]   d_branchfunct,   // REGIMM rt
    input  logic [sub_w-1:0]   d_c0funct,       // COP0 rs
    output logic               d_memreq,
    output logic               d_regwrite,
    output logic [1:0]         d_regdst,        // 00 rt, 01 rd, 10 r31
    output logic               d_cp0write,
    output logic               d_hiwrite,
    output logic               d_lowrite,
    output logic               d_isbranch,
    output logic               d_isjump,
    output logic               d_needrs,
    output logic               d_needrt,
    output logic               d_needhi,
    output logic               d_needlo,
    output logic               d_needcp0
);

    instr_e  instr;
    regdst_e regdst;

    inst_identify u_inst_identify (
        .d_op          (d_op),
        .d_funct       (d_funct),
        .d_branchfunct (d_branchfunct),
        .d_c0funct     (d_c0funct),
        .instr         (instr)
    );

    dest_decode u_dest_decode (
        .instr    (instr),
        .regwrite (d_regwrite),
        .hiwrite  (d_hiwrite),
        .lowrite  (d_lowrite),
        .cp0write (d_cp0write),
        .regdst   (regdst)
    );

    operand_decode u_operand_decode (
        .instr   (instr),
        .needrs  (d_needrs),
        .needrt  (d_needrt),
        .needhi  (d_needhi),
        .needlo  (d_needlo),
        .needcp0 (d_needcp0)
    );

    pipe_class_decode u_pipe_class_decode (
        .instr    (instr),
        .isbranch (d_isbranch),
        .isjump   (d_isjump),
        .memreq   (d_memreq)
    );

    assign d_regdst = regdst;

endmodule

// File: sim/issue_checker.sv
`timescale 1ns/100ps

module issue_checker
    import issue_pkg::*;
(
    input logic               clk,
    input logic               rst_n,
    input logic [op_w-1:0]    d_op,
    input logic [funct_w-1:0] d_funct,
    input logic [sub_w-1:0]   d_branchfunct,
    input logic [sub_w-1:0]   d_c0funct,
    input logic               d_memreq,
    input logic               d_regwrite,
    input logic [1:0]         d_regdst,
    input logic               d_cp0write,
    input logic               d_hiwrite,
    input logic               d_lowrite,
    input logic               d_isbranch,
    input logic               d_isjump,
    input logic               d_needrs,
    input logic               d_needrt,
    input logic               d_needhi,
    input logic               d_needlo,
    input logic               d_needcp0
);

    typedef struct packed {
        logic       memreq;
        logic       regwrite;
        logic [1:0] regdst;
        logic       cp0write;
        logic       hiwrite;
        logic       lowrite;
        logic       isbranch;
        logic       isjump;
        logic       needrs;
        logic       needrt;
        logic       needhi;
        logic       needlo;
        logic       needcp0;
    } ctrl_t;

    int    error_count = 0;
    int    check_count = 0;
    ctrl_t want;

    function automatic ctrl_t expected_outputs(input logic [op_w-1:0] op,
                                               input logic [funct_w-1:0] funct,
                                               input logic [sub_w-1:0] rt,
                                               input logic [sub_w-1:0] rs);
        ctrl_t e;
        logic  sp;
        logic  sp_rd;       // SPECIAL ops that write rd
        logic  sp_md;
        logic  sp_known;
        logic  imm;
        logic  load;
        logic  store;
        logic  branch;
        logic  ri_link;
        logic  eret;
        logic  mfc0;
        logic  mtc0;
        e        = '0;
        sp       = (op == OP_SPECIAL);
        sp_rd    = sp && (funct inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                                        FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SRL,
                                        FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV,
                                        FN_JALR, FN_MFHI, FN_MFLO});
        sp_md    = sp && (funct inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU});
        sp_known = sp_rd || sp_md ||
                   (sp && (funct inside {FN_JR, FN_MTHI, FN_MTLO, FN_SYSCALL, FN_BREAK}));
        imm      = op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
                              OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        load     = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        store    = op inside {OP_SB, OP_SH, OP_SW};
        branch   = (op == OP_REGIMM) || (op inside {OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ});
        ri_link  = (op == OP_REGIMM) && !(rt inside {RI_BLTZ, RI_BGEZ});   // Unknown rt links
        eret     = (op == OP_COP0) && (funct == FN_ERET);
        mfc0     = (op == OP_COP0) && !eret && (rs == C0_MF);
        mtc0     = (op == OP_COP0) && !eret && (rs == C0_MT);

        e.regwrite = sp_rd || imm || load || ri_link || (op == OP_JAL) || mfc0;
        if (sp_rd)
            e.regdst = REGDST_RD;
        else if (ri_link || (op == OP_JAL))
            e.regdst = REGDST_R31;
        else
            e.regdst = REGDST_RT;
        e.hiwrite  = sp_md || (sp && (funct == FN_MTHI));
        e.lowrite  = sp_md || (sp && (funct == FN_MTLO));
        e.cp0write = mtc0;
        e.needrs   = (sp_known && !(funct inside {FN_SLL, FN_SRL, FN_SRA, FN_MFHI, FN_MFLO,
                                                  FN_BREAK, FN_SYSCALL})) ||
                     (imm && (op != OP_LUI)) || branch || load || store;
        e.needrt   = (sp_rd && !(funct inside {FN_JALR, FN_MFHI, FN_MFLO})) || sp_md ||
                     (op inside {OP_BEQ, OP_BNE}) || store || mtc0;
        e.needhi   = sp && (funct == FN_MFHI);
        e.needlo   = sp && (funct == FN_MFLO);
        e.needcp0  = eret || mfc0;
        e.isbranch = branch;
        e.isjump   = (sp && (funct inside {FN_JR, FN_JALR})) || (op inside {OP_J, OP_JAL});
        e.memreq   = load || store;
        return e;
    endfunction

    task automatic check_bit(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v)
        begin
            error_count++;
            $display("error at %0t: %s expected %b got %b", $time, name, exp_v, act_v);
        end
    endtask

    task automatic check_pair(input string name, input logic [1:0] exp_v,
                              input logic [1:0] act_v);
        if (act_v !== exp_v)
        begin
            error_count++;
            $display("error at %0t: %s expected %b got %b", $time, name, exp_v, act_v);
        end
    endtask

    // Outputs have settled half a cycle after the fields change
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            want = expected_outputs(d_op, d_funct, d_branchfunct, d_c0funct);
            check_bit("d_memreq", want.memreq, d_memreq);
            check_bit("d_regwrite", want.regwrite, d_regwrite);
            check_pair("d_regdst", want.regdst, d_regdst);
            check_bit("d_cp0write", want.cp0write, d_cp0write);
            check_bit("d_hiwrite", want.hiwrite, d_hiwrite);
            check_bit("d_lowrite", want.lowrite, d_lowrite);
            check_bit("d_isbranch", want.isbranch, d_isbranch);
            check_bit("d_isjump", want.isjump, d_isjump);
            check_bit("d_needrs", want.needrs, d_needrs);
            check_bit("d_needrt", want.needrt, d_needrt);
            check_bit("d_needhi", want.needhi, d_needhi);
            check_bit("d_needlo", want.needlo, d_needlo);
            check_bit("d_needcp0", want.needcp0, d_needcp0);
            check_count++;
        end
    end

endmodule

// File: sim/tb_issue_controller.sv
`timescale 1ns/100ps

module tb_issue_controller
    import issue_pkg::*;
();

    // 29 SPECIAL, 22 opcodes, 6 REGIMM, 6 COP0, 4 unknown opcodes
    localparam int directed_len = 67;
    localparam int random_len   = 2000;
    localparam int cycle_limit  = directed_len + random_len + 50;

    logic               clk;
    logic               rst_n;
    logic [op_w-1:0]    d_op;
    logic [funct_w-1:0] d_funct;
    logic [sub_w-1:0]   d_branchfunct;
    logic [sub_w-1:0]   d_c0funct;
    logic               d_memreq;
    logic               d_regwrite;
    logic [1:0]         d_regdst;
    logic               d_cp0write;
    logic               d_hiwrite;
    logic               d_lowrite;
    logic               d_isbranch;
    logic               d_isjump;
    logic               d_needrs;
    logic               d_needrt;
    logic               d_needhi;
    logic               d_needlo;
    logic               d_needcp0;
    int                 cycle_count = 0;
    int                 seed = 30460;

    issue_controller DUT (.*);

    issue_checker issue_chk (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout: stimulus still running after %0d cycles", cycle_count);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic apply_fields(input logic [op_w-1:0] op, input logic [funct_w-1:0] funct,
                                input logic [sub_w-1:0] rt, input logic [sub_w-1:0] rs);
        @(posedge clk);
        d_op          <= op;
        d_funct       <= funct;
        d_branchfunct <= rt;
        d_c0funct     <= rs;
    endtask

    task automatic run_special();
        funct_e fn;
        fn = fn.first();
        repeat (fn.num())
        begin
            apply_fields(OP_SPECIAL, fn, 5'd0, 5'd0);
            fn = fn.next();
        end
        apply_fields(OP_SPECIAL, 6'b111111, 5'd0, 5'd0);   // Unknown funct
    endtask

    // Sub-fields hold junk so the decode has to ignore them
    task automatic run_opcodes();
        op_e op;
        op = op.first();
        repeat (op.num())
        begin
            if (!(op inside {OP_SPECIAL, OP_REGIMM, OP_COP0}))
                apply_fields(op, 6'b101010, 5'b10001, 5'b00100);
            op = op.next();
        end
    endtask

    task automatic run_regimm_cop0();
        regimm_e ri;
        ri = ri.first();
        repeat (ri.num())
        begin
            apply_fields(OP_REGIMM, 6'd0, ri, 5'd0);
            ri = ri.next();
        end
        apply_fields(OP_REGIMM, 6'd0, 5'b00010, 5'd0);
        apply_fields(OP_REGIMM, 6'd0, 5'b11111, 5'd0);
        apply_fields(OP_COP0, FN_ERET, 5'd0, C0_MT);        // ERET must not write CP0
        apply_fields(OP_COP0, 6'd0, 5'd0, C0_MF);
        apply_fields(OP_COP0, 6'd0, 5'd0, C0_MT);
        apply_fields(OP_COP0, 6'd0, 5'd0, 5'b00001);
        apply_fields(OP_COP0, 6'd0, 5'd0, 5'b01000);
        apply_fields(OP_COP0, 6'd0, 5'd0, 5'b11111);
    endtask

    task automatic run_random();
        logic [31:0] rnd;
        repeat (random_len)
        begin
            rnd = $random(seed);
            apply_fields(rnd[5:0], rnd[11:6], rnd[16:12], rnd[21:17]);
        end
    endtask

    initial
    begin
        rst_n         <= 1'b0;
        d_op          <= '0;
        d_funct       <= '0;
        d_branchfunct <= '0;
        d_c0funct     <= '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        run_special();
        run_opcodes();
        run_regimm_cop0();
        apply_fields(6'b010001, 6'd0, 5'd0, 5'd0);
        apply_fields(6'b011111, 6'd0, 5'd0, 5'd0);
        apply_fields(6'b100010, 6'd0, 5'd0, 5'd0);
        apply_fields(6'b111111, 6'd0, 5'd0, 5'd0);
        run_random();
        @(posedge clk);   // Last vector compared on the falling edge before this
        $display("errors: %0d  checks: %0d", issue_chk.error_count, issue_chk.check_count);
        if (issue_chk.error_count == 0 && issue_chk.check_count > 0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            if (issue_chk.check_count == 0)
                $display("no output comparisons were made");
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: issue_controller.f
verilog/issue_pkg.sv
verilog/inst_identify.sv
verilog/dest_decode.sv
verilog/operand_decode.sv
verilog/pipe_class_decode.sv
verilog/issue_controller.sv
sim/issue_checker.sv
sim/tb_issue_controller.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the issue controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f issue_controller.f \
    --top-module tb_issue_controller -Mdir obj_dir -o tb_issue_controller > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/tb_issue_controller > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
    exit 0
fi
exit 1
